// ==== ocl_hash_cfg.svh ====
// OCL hash endpoint configuration
`ifndef OCL_HASH_CFG_SVH
`define OCL_HASH_CFG_SVH

// --------------------------------------------------
// Lane array geometry
// --------------------------------------------------
// Number of hash lanes behind the slave
`define OCL_LANE_CNT     8
// Writable words per lane window
`define OCL_LANE_WORDS   4
// Byte address of lane 0's window
`define OCL_LANE_BASE    16'h0100
// Byte size of each lane window
`define OCL_LANE_STRIDE  16'h0020

// --------------------------------------------------
// Local registers
// --------------------------------------------------
// Hello-world word, reads back byte-swapped
`define OCL_HELLO_ADDR   16'h0500
// Virtual LED shadow readback
`define OCL_VLED_ADDR    16'h0504
// Width of LED and DIP vectors
`define OCL_VLED_W       16

`endif

// ==== ocl_hash_pkg.sv ====
// OCL hash shared types
`include "ocl_hash_cfg.svh"

package ocl_hash_pkg;

  // AXI-Lite field types
  typedef logic [15:0] ocl_addr_t;
  typedef logic [31:0] ocl_data_t;
  typedef logic [3:0]  ocl_strb_t;
  typedef logic [1:0]  ocl_resp_t;

  // LED and DIP switch vector
  typedef logic [`OCL_VLED_W-1:0] vled_t;

  // Read response payload, data above response code
  typedef struct packed {
    ocl_data_t data;
    ocl_resp_t resp;
  } rd_rsp_t;

  // Byte-lane merge of a write into a stored word
  function automatic ocl_data_t apply_strb(ocl_data_t old_word, ocl_data_t new_word,
                                           ocl_strb_t strb);
    ocl_data_t result;
    result = old_word;
    for (int b = 0; b < $bits(ocl_strb_t); b++)
    begin
      if (strb[b])
        result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

endpackage

// ==== lane_bus_if.sv ====
// Lane broadcast bus
`timescale 1ns/1ps

interface lane_bus_if;
  import ocl_hash_pkg::*;

  // One-cycle pulse per accepted access
  logic      req_valid;
  // High for write, low for read
  logic      req_we;
  // Byte address of the access
  ocl_addr_t req_addr;
  // Write payload, ignored on reads
  ocl_data_t req_wdata;
  ocl_strb_t req_strb;

  // --------------------------------------------------
  // Views
  // --------------------------------------------------
  // Front end owns every signal
  modport front (
    output req_valid, req_we, req_addr, req_wdata, req_strb
  );

  // Lanes decode the full request
  modport lane (
    input req_valid, req_we, req_addr, req_wdata, req_strb
  );

  // Merger only needs to spot read pulses
  modport merge (
    input req_valid, req_we
  );

endinterface

// ==== reg_slice.sv ====
// Valid/ready register slice
`timescale 1ns/1ps

module reg_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  // Upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // Downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  // Room when empty, or when the held item leaves this cycle
  assign in_ready = ~valid_q | out_ready;

  // Occupancy flag
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      valid_q <= 1'b0;
    else if (in_ready)
      valid_q <= in_valid;
  end

  // Payload capture on the input handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (in_valid && in_ready)
      data_q <= in_data;
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

endmodule

// ==== ocl_front.sv ====
// OCL slave front end
`timescale 1ns/1ps
`include "ocl_hash_cfg.svh"

module ocl_front (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  // Write address
  input  logic                    awvalid,
  output logic                    awready,
  input  ocl_hash_pkg::ocl_addr_t awaddr,
  // Write data
  input  logic                    wvalid,
  output logic                    wready,
  input  ocl_hash_pkg::ocl_data_t wdata,
  input  ocl_hash_pkg::ocl_strb_t wstrb,
  // Write response
  output logic                    bvalid,
  input  logic                    bready,
  output ocl_hash_pkg::ocl_resp_t bresp,
  // Read address from the address slice
  input  logic                    rd_valid,
  output logic                    rd_ready,
  input  ocl_hash_pkg::ocl_addr_t rd_addr,
  // Top-level r handshake
  input  logic                    rd_done,
  output ocl_hash_pkg::ocl_data_t local_rdata,
  // Virtual switches and LEDs
  input  ocl_hash_pkg::vled_t     vdip,
  output ocl_hash_pkg::vled_t     vled,
  lane_bus_if.front               bus
);
  import ocl_hash_pkg::*;

  typedef enum logic [1:0] {WR_BOOT, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

  wr_state_t wr_state_q;
  ocl_addr_t wr_addr_q;
  logic      wr_fire;
  logic      rd_fire;
  logic      rd_busy_q;
  ocl_data_t hello_q;
  ocl_data_t hello_swap;
  ocl_data_t local_sel;
  ocl_data_t local_rdata_q;
  vled_t     vdip_q1;
  vled_t     vdip_q2;
  vled_t     vled_shadow_q;
  vled_t     vled_q;

  // --------------------------------------------------
  // Write sequencing
  // --------------------------------------------------
  // Ready and valid come straight from the state
  assign awready = (wr_state_q == WR_ADDR);
  assign wready  = (wr_state_q == WR_DATA);
  assign bvalid  = (wr_state_q == WR_RESP);
  // Always OKAY
  assign bresp   = '0;
  assign wr_fire = wvalid & wready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      wr_state_q <= WR_BOOT;
    else
    begin
      case (wr_state_q)
        // One idle cycle out of reset
        WR_BOOT: wr_state_q <= WR_ADDR;
        WR_ADDR: if (awvalid) wr_state_q <= WR_DATA;
        WR_DATA: if (wvalid) wr_state_q <= WR_RESP;
        WR_RESP: if (bready) wr_state_q <= WR_ADDR;
        default: wr_state_q <= WR_ADDR;
      endcase
    end
  end

  // Address held for the data beat
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr_q <= awaddr;
  end

  // --------------------------------------------------
  // Read sequencing and broadcast
  // --------------------------------------------------
  // One read in flight; a write beat takes the bus first
  assign rd_ready = ~rd_busy_q & ~wr_fire;
  assign rd_fire  = rd_valid & rd_ready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rd_busy_q <= 1'b0;
    else if (rd_fire)
      rd_busy_q <= 1'b1;
    else if (rd_done)
      rd_busy_q <= 1'b0;
  end

  // Same-cycle pulse to lanes and merger
  assign bus.req_valid = wr_fire | rd_fire;
  assign bus.req_we    = wr_fire;
  assign bus.req_addr  = wr_fire ? wr_addr_q : rd_addr;
  assign bus.req_wdata = wdata;
  assign bus.req_strb  = wr_fire ? wstrb : '0;

  // --------------------------------------------------
  // Hello-world register
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q <= '0;
    else if (wr_fire && (wr_addr_q == `OCL_HELLO_ADDR))
      hello_q <= apply_strb(hello_q, wdata, wstrb);
  end

  // Byte order reversed on readback
  assign hello_swap = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // Local read word, zero unless addressed
  always_comb
  begin
    case (rd_addr)
      `OCL_HELLO_ADDR: local_sel = hello_swap;
      `OCL_VLED_ADDR:  local_sel = ocl_data_t'(vled_shadow_q);
      default:         local_sel = '0;
    endcase
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      local_rdata_q <= '0;
    else
      local_rdata_q <= rd_fire ? local_sel : '0;
  end

  assign local_rdata = local_rdata_q;

  // --------------------------------------------------
  // Virtual LEDs
  // --------------------------------------------------
  // Two-flop sync on the DIPs, shadow of the low half
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1       <= '0;
      vdip_q2       <= '0;
      vled_shadow_q <= '0;
      vled_q        <= '0;
    end
    else
    begin
      vdip_q1       <= vdip;
      vdip_q2       <= vdip_q1;
      vled_shadow_q <= hello_q[`OCL_VLED_W-1:0];
      // LEDs lit only where the switch is on
      vled_q        <= vled_shadow_q & vdip_q2;
    end
  end

  assign vled = vled_q;

endmodule

// ==== hash_lane.sv ====
// Hash lane register window
`timescale 1ns/1ps
`include "ocl_hash_cfg.svh"

module hash_lane #(
  parameter int lane_coef = 1
) (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  lane_bus_if.lane                bus,
  output ocl_hash_pkg::ocl_data_t rdata
);
  import ocl_hash_pkg::*;

  // Window start for this lane
  localparam int win_base = `OCL_LANE_BASE + (lane_coef - 1) * `OCL_LANE_STRIDE;

  ocl_data_t                      words_q [`OCL_LANE_WORDS];
  ocl_addr_t                      offset;
  logic [$bits(ocl_addr_t)-3:0]   word_idx;
  logic                           hit;
  ocl_data_t                      rd_word;
  ocl_data_t                      rdata_q;

  // Below the base wraps high and misses
  assign offset   = bus.req_addr - ocl_addr_t'(win_base);
  assign hit      = (offset < ocl_addr_t'(`OCL_LANE_STRIDE));
  assign word_idx = offset[$bits(ocl_addr_t)-1:2];

  // Word select within the window
  always_comb
  begin
    rd_word = '0;
    // Coefficient word sits just past the writable words
    if (word_idx == `OCL_LANE_WORDS)
      rd_word = ocl_data_t'(lane_coef);
    for (int i = 0; i < `OCL_LANE_WORDS; i++)
    begin
      if (word_idx == i)
        rd_word = words_q[i];
    end
  end

  // Strobed writes, other offsets dropped
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      for (int i = 0; i < `OCL_LANE_WORDS; i++)
        words_q[i] <= '0;
    end
    else if (bus.req_valid && bus.req_we && hit)
    begin
      for (int i = 0; i < `OCL_LANE_WORDS; i++)
      begin
        if (word_idx == i)
          words_q[i] <= apply_strb(words_q[i], bus.req_wdata, bus.req_strb);
      end
    end
  end

  // Zero unless this lane was read last cycle
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rdata_q <= '0;
    else
      rdata_q <= (bus.req_valid && !bus.req_we && hit) ? rd_word : '0;
  end

  assign rdata = rdata_q;

endmodule

// ==== rsp_merge.sv ====
// Read response merger
`timescale 1ns/1ps
`include "ocl_hash_cfg.svh"

module rsp_merge (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  lane_bus_if.merge               bus,
  input  ocl_hash_pkg::ocl_data_t lane_rdata [`OCL_LANE_CNT],
  input  ocl_hash_pkg::ocl_data_t local_rdata,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output ocl_hash_pkg::rd_rsp_t   rsp
);
  import ocl_hash_pkg::*;

  logic      rd_pulse_q;
  logic      rsp_valid_q;
  ocl_data_t merged;
  rd_rsp_t   rsp_q;

  // Read pulse delayed to line up with lane words
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rd_pulse_q <= 1'b0;
    else
      rd_pulse_q <= bus.req_valid & ~bus.req_we;
  end

  // At most one source is non-zero
  always_comb
  begin
    merged = local_rdata;
    for (int i = 0; i < `OCL_LANE_CNT; i++)
      merged = merged | lane_rdata[i];
  end

  // Held until the response slice takes it
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rsp_valid_q <= 1'b0;
    else if (rd_pulse_q)
      rsp_valid_q <= 1'b1;
    else if (rsp_ready)
      rsp_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_pulse_q)
    begin
      rsp_q.data <= merged;
      // OKAY
      rsp_q.resp <= '0;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

endmodule

// ==== ocl_hash_top.sv ====
// OCL hash endpoint top
`timescale 1ns/1ps
`include "ocl_hash_cfg.svh"

module ocl_hash_top (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  // Write address
  input  logic                    awvalid,
  output logic                    awready,
  input  ocl_hash_pkg::ocl_addr_t awaddr,
  // Write data
  input  logic                    wvalid,
  output logic                    wready,
  input  ocl_hash_pkg::ocl_data_t wdata,
  input  ocl_hash_pkg::ocl_strb_t wstrb,
  // Write response
  output logic                    bvalid,
  input  logic                    bready,
  output ocl_hash_pkg::ocl_resp_t bresp,
  // Read address
  input  logic                    arvalid,
  output logic                    arready,
  input  ocl_hash_pkg::ocl_addr_t araddr,
  // Read data
  output logic                    rvalid,
  input  logic                    rready,
  output ocl_hash_pkg::ocl_data_t rdata,
  output ocl_hash_pkg::ocl_resp_t rresp,
  // Virtual switches and LEDs
  input  ocl_hash_pkg::vled_t     vdip,
  output ocl_hash_pkg::vled_t     vled
);
  import ocl_hash_pkg::*;

  logic      ar_q_valid;
  logic      ar_q_ready;
  ocl_addr_t ar_q_addr;
  ocl_data_t lane_rdata [`OCL_LANE_CNT];
  ocl_data_t local_rdata;
  logic      rsp_valid;
  logic      rsp_ready;
  rd_rsp_t   rsp;
  rd_rsp_t   r_out;
  logic      rd_done;

  lane_bus_if lane_bus ();

  // Read completes on the top-level r handshake
  assign rd_done = rvalid & rready;
  assign rdata   = r_out.data;
  assign rresp   = r_out.resp;

  // --------------------------------------------------
  // Read address slice
  // --------------------------------------------------
  reg_slice #(.payload_t(ocl_addr_t)) u_ar_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .in_valid        (arvalid),
    .in_ready        (arready),
    .in_data         (araddr),
    .out_valid       (ar_q_valid),
    .out_ready       (ar_q_ready),
    .out_data        (ar_q_addr)
  );

  ocl_front u_front (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awready         (awready),
    .awaddr          (awaddr),
    .wvalid          (wvalid),
    .wready          (wready),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .bvalid          (bvalid),
    .bready          (bready),
    .bresp           (bresp),
    .rd_valid        (ar_q_valid),
    .rd_ready        (ar_q_ready),
    .rd_addr         (ar_q_addr),
    .rd_done         (rd_done),
    .local_rdata     (local_rdata),
    .vdip            (vdip),
    .vled            (vled),
    .bus             (lane_bus)
  );

  // --------------------------------------------------
  // Lane array, one window per lane
  // --------------------------------------------------
  for (genvar k = 0; k < `OCL_LANE_CNT; k++)
  begin : g_lane
    hash_lane #(.lane_coef(k + 1)) u_lane (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .bus             (lane_bus),
      .rdata           (lane_rdata[k])
    );
  end

  rsp_merge u_merge (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (lane_bus),
    .lane_rdata      (lane_rdata),
    .local_rdata     (local_rdata),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp             (rsp)
  );

  // Response slice drives the r channel
  reg_slice #(.payload_t(rd_rsp_t)) u_r_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .in_valid        (rsp_valid),
    .in_ready        (rsp_ready),
    .in_data         (rsp),
    .out_valid       (rvalid),
    .out_ready       (rready),
    .out_data        (r_out)
  );

endmodule

// ==== ocl_hash_chk.sv ====
// AXI-Lite handshake assertions
`timescale 1ns/1ps

module ocl_hash_chk (
  input logic                    clk_main_a0,
  input logic                    rst_main_n_sync,
  input logic                    awvalid,
  input logic                    awready,
  input logic                    wvalid,
  input logic                    wready,
  input logic                    bvalid,
  input logic                    bready,
  input logic                    arvalid,
  input logic                    arready,
  input logic                    rvalid,
  input logic                    rready,
  input ocl_hash_pkg::ocl_data_t rdata
);

  logic ar_fire;
  logic r_fire;
  int   rd_outstanding;
  // Count of failed assertions
  int   assert_fails = 0;

  assign ar_fire = arvalid & arready;
  assign r_fire  = rvalid & rready;

  // Reads accepted but not yet answered
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rd_outstanding <= 0;
    else if (ar_fire && !r_fire)
      rd_outstanding <= rd_outstanding + 1;
    else if (r_fire && !ar_fire)
      rd_outstanding <= rd_outstanding - 1;
  end

  // --------------------------------------------------
  // Valid holds until ready
  // --------------------------------------------------
  a_aw_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    awvalid && !awready |=> awvalid)
    else
    begin
      assert_fails++;
      $error("awvalid dropped before awready");
    end
  a_w_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wvalid && !wready |=> wvalid)
    else
    begin
      assert_fails++;
      $error("wvalid dropped before wready");
    end
  a_b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else
    begin
      assert_fails++;
      $error("bvalid dropped before bready");
    end
  a_ar_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    arvalid && !arready |=> arvalid)
    else
    begin
      assert_fails++;
      $error("arvalid dropped before arready");
    end
  // Stalled read data stays put
  a_r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else
    begin
      assert_fails++;
      $error("rvalid or rdata changed while stalled");
    end

  // --------------------------------------------------
  // Response ordering
  // --------------------------------------------------
  a_b_after_w: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wvalid && wready |=> bvalid)
    else
    begin
      assert_fails++;
      $error("bvalid missing one cycle after the w handshake");
    end
  a_b_cause: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(bvalid) |-> $past(wvalid && wready))
    else
    begin
      assert_fails++;
      $error("bvalid rose without a w handshake");
    end
  a_r_cause: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid |-> rd_outstanding != 0)
    else
    begin
      assert_fails++;
      $error("rvalid high with no read outstanding");
    end

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns = 4
) (
  output logic clk_main_a0
);

  // Free-running clock, low at time zero
  initial
  begin
    clk_main_a0 = 1'b0;
    forever
      #(period_ns / 2) clk_main_a0 = ~clk_main_a0;
  end

endmodule

// ==== ocl_hash_tb.sv ====
// OCL hash endpoint testbench
`timescale 1ns/1ps
`include "ocl_hash_cfg.svh"

module ocl_hash_tb;
  import ocl_hash_pkg::*;

  localparam int        SEED       = 41730;
  localparam int        DRIVE_DLY  = 1;
  localparam int        RD_LATENCY = 4;
  localparam int        NUM_HELLO  = 12;
  localparam int        NUM_LANE   = 48;
  localparam int        NUM_UNMAP  = 16;
  localparam ocl_resp_t OKAY       = 2'b00;
  localparam int        WIN_END    = `OCL_LANE_BASE + `OCL_LANE_CNT * `OCL_LANE_STRIDE;
  // Each write, read or LED settle counts once
  localparam int        TOTAL_TXN  = NUM_HELLO * 5 + NUM_LANE * 3 + `OCL_LANE_CNT +
                                     NUM_UNMAP * 3 + 2;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  logic      awvalid;
  logic      awready;
  ocl_addr_t awaddr;
  logic      wvalid;
  logic      wready;
  ocl_data_t wdata;
  ocl_strb_t wstrb;
  logic      bvalid;
  logic      bready;
  ocl_resp_t bresp;
  logic      arvalid;
  logic      arready;
  ocl_addr_t araddr;
  logic      rvalid;
  logic      rready;
  ocl_data_t rdata;
  ocl_resp_t rresp;
  vled_t     vdip;
  vled_t     vled;

  // Reference model state
  ocl_data_t lane_model [`OCL_LANE_CNT][`OCL_LANE_WORDS];
  ocl_data_t hello_model;
  vled_t     vdip_model;
  int        fail_count;

  tb_clk_gen #(.period_ns(4)) u_clk_gen (.clk_main_a0(clk_main_a0));

  ocl_hash_top u_ocl_hash_top (.*);

  bind ocl_hash_top ocl_hash_chk u_chk (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awready         (awready),
    .wvalid          (wvalid),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .arready         (arready),
    .rvalid          (rvalid),
    .rready          (rready),
    .rdata           (rdata)
  );

  // --------------------------------------------------
  // Model rules
  // --------------------------------------------------
  function automatic bit random_bit();
    return ($urandom % 2) == 0;
  endfunction

  // Strobe bits widened to a byte mask
  function automatic ocl_data_t merge_bytes(ocl_data_t old_word, ocl_data_t new_word,
                                            ocl_strb_t strb);
    ocl_data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic ocl_addr_t lane_addr(int lane, int word);
    return ocl_addr_t'(`OCL_LANE_BASE + lane * `OCL_LANE_STRIDE + word * 4);
  endfunction

  function automatic ocl_data_t expected_read(ocl_addr_t addr);
    int rel;
    int lane;
    int word;
    // Hello word comes back in reversed byte order
    if (addr == `OCL_HELLO_ADDR)
      return {<<8{hello_model}};
    if (addr == `OCL_VLED_ADDR)
      return ocl_data_t'(hello_model[`OCL_VLED_W-1:0]);
    if (int'(addr) < `OCL_LANE_BASE || int'(addr) >= WIN_END)
      return '0;
    rel  = int'(addr) - `OCL_LANE_BASE;
    lane = rel / `OCL_LANE_STRIDE;
    word = (rel % `OCL_LANE_STRIDE) / 4;
    if (word < `OCL_LANE_WORDS)
      return lane_model[lane][word];
    // Coefficient is lane index plus one
    if (word == `OCL_LANE_WORDS)
      return ocl_data_t'(lane + 1);
    return '0;
  endfunction

  task automatic model_write(ocl_addr_t addr, ocl_data_t data, ocl_strb_t strb);
    int rel;
    int word;
    rel  = int'(addr) - `OCL_LANE_BASE;
    word = (rel % `OCL_LANE_STRIDE) / 4;
    if (addr == `OCL_HELLO_ADDR)
      hello_model = merge_bytes(hello_model, data, strb);
    else if (rel >= 0 && int'(addr) < WIN_END && word < `OCL_LANE_WORDS)
      lane_model[rel / `OCL_LANE_STRIDE][word] =
        merge_bytes(lane_model[rel / `OCL_LANE_STRIDE][word], data, strb);
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic report_failure(string msg);
    fail_count++;
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rd(rd_rsp_t got, rd_rsp_t exp, ocl_addr_t addr);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: rdata/rresp at 0x%h got %h/%0d expected %h/%0d",
                               $time, addr, got.data, got.resp, exp.data, exp.resp));
  endtask

  task automatic check_vled(vled_t got, vled_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: vled got %h expected %h", $time, got, exp));
  endtask

  task automatic check_bresp(ocl_resp_t got, ocl_resp_t exp);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: bresp got %0d expected %0d", $time, got, exp));
  endtask

  // --------------------------------------------------
  // Bus tasks
  // --------------------------------------------------
  // Address first, then data, then b with random stalls
  task automatic axi_write(ocl_addr_t addr, ocl_data_t data, ocl_strb_t strb);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    awvalid = 1'b1;
    awaddr  = addr;
    do
      @(negedge clk_main_a0);
    while (!awready);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    do
      @(negedge clk_main_a0);
    while (!wready);
    model_write(addr, data, strb);
    do
    begin
      @(posedge clk_main_a0);
      #DRIVE_DLY;
      wvalid = 1'b0;
      bready = random_bit();
      @(negedge clk_main_a0);
    end
    while (!(bvalid && bready));
    check_bresp(bresp, OKAY);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  // Each cycle with rvalid high is compared against the model
  task automatic axi_read(ocl_addr_t addr, bit hold);
    rd_rsp_t exp;
    rd_rsp_t got;
    int      cycles;
    bit      seen;
    bit      done;
    exp.data = expected_read(addr);
    exp.resp = OKAY;
    cycles   = 0;
    seen     = 1'b0;
    done     = 1'b0;
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    arvalid = 1'b1;
    araddr  = addr;
    do
      @(negedge clk_main_a0);
    while (!arready);
    while (!done)
    begin
      @(posedge clk_main_a0);
      #DRIVE_DLY;
      arvalid = 1'b0;
      rready  = hold ? 1'b1 : random_bit();
      @(negedge clk_main_a0);
      cycles++;
      if (rvalid)
      begin
        if (!seen && hold && cycles != RD_LATENCY)
          report_failure($sformatf("mismatch at %0t: read latency at 0x%h got %0d expected %0d",
                                   $time, addr, cycles, RD_LATENCY));
        seen     = 1'b1;
        got.data = rdata;
        got.resp = rresp;
        check_rd(got, exp, addr);
        done     = rready;
      end
    end
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    rready = 1'b0;
  endtask

  task automatic set_vdip(vled_t value);
    @(posedge clk_main_a0);
    #DRIVE_DLY;
    vdip       = value;
    vdip_model = value;
  endtask

  // LEDs given time to pass sync and shadow stages
  task automatic settle_and_check_vled();
    repeat (8) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    check_vled(vled, hello_model[`OCL_VLED_W-1:0] & vdip_model);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin : main_flow
    ocl_addr_t addr;
    ocl_strb_t strb;
    int        lane;
    int        word;
    void'($urandom(SEED));
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    vdip            = '0;
    vdip_model      = '0;
    hello_model     = '0;
    fail_count      = 0;
    for (int l = 0; l < `OCL_LANE_CNT; l++)
    begin
      for (int w = 0; w < `OCL_LANE_WORDS; w++)
        lane_model[l][w] = '0;
    end
    repeat (10) @(posedge clk_main_a0);
    #DRIVE_DLY;
    rst_main_n_sync = 1'b1;

    // Idle cycle out of reset
    @(negedge clk_main_a0);
    if (awready)
      report_failure("awready was high in the first cycle after reset");
    if (bvalid || rvalid || wready)
      report_failure("a response or wready was high right after reset");
    check_vled(vled, '0);

    // Hello-world register and LEDs
    for (int i = 0; i < NUM_HELLO; i++)
    begin
      strb = ocl_strb_t'($urandom % 16);
      axi_write(`OCL_HELLO_ADDR, $urandom, strb);
      axi_read(`OCL_HELLO_ADDR, random_bit());
      axi_read(`OCL_VLED_ADDR, random_bit());
      if (random_bit())
        set_vdip(vled_t'($urandom));
      settle_and_check_vled();
    end
    set_vdip('1);
    settle_and_check_vled();

    // Lane words with strobes
    for (int i = 0; i < NUM_LANE; i++)
    begin
      lane = $urandom % `OCL_LANE_CNT;
      word = $urandom % `OCL_LANE_WORDS;
      strb = ocl_strb_t'($urandom % 16);
      axi_write(lane_addr(lane, word), $urandom, strb);
      axi_read(lane_addr(lane, word), random_bit());
      lane = $urandom % `OCL_LANE_CNT;
      word = $urandom % `OCL_LANE_WORDS;
      axi_read(lane_addr(lane, word), random_bit());
    end

    // Coefficient readback per lane
    for (int l = 0; l < `OCL_LANE_CNT; l++)
      axi_read(lane_addr(l, `OCL_LANE_WORDS), random_bit());

    // Unused offsets and addresses outside every window
    for (int i = 0; i < NUM_UNMAP; i++)
    begin
      lane = $urandom % `OCL_LANE_CNT;
      word = `OCL_LANE_WORDS + 1 +
             ($urandom % (`OCL_LANE_STRIDE / 4 - `OCL_LANE_WORDS - 1));
      if (i % 4 == 0)
        axi_write(lane_addr(lane, word), $urandom, 4'hf);
      axi_read(lane_addr(lane, word), random_bit());
      if (i % 2 == 0)
        addr = ocl_addr_t'(WIN_END + 4 * ($urandom % ((`OCL_HELLO_ADDR - WIN_END) / 4)));
      else
        addr = ocl_addr_t'(4 * ($urandom % (`OCL_LANE_BASE / 4)));
      axi_read(addr, random_bit());
    end

    // Bound assertion failures count as errors too
    fail_count += u_ocl_hash_top.u_chk.assert_fails;
    if (fail_count == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("tests failed");
      $fatal(1, "errors were recorded");
    end
  end

  // Run length bound
  initial
  begin : watchdog
    repeat (TOTAL_TXN * 40) @(posedge clk_main_a0);
    $display("timeout: run did not finish within %0d cycles", TOTAL_TXN * 40);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verilog.f ====
+incdir+.
ocl_hash_pkg.sv
lane_bus_if.sv
reg_slice.sv
ocl_front.sv
hash_lane.sv
rsp_merge.sv
ocl_hash_top.sv
ocl_hash_chk.sv
tb_clk_gen.sv
ocl_hash_tb.sv

// ==== Makefile ====
# Verilator build and run for the OCL hash endpoint

TOP       ?= ocl_hash_tb
SEED      ?= 1
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LOG       ?= sim.log

FILELIST  := verilog.f
SRCS      := $(wildcard *.sv *.svh)
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
